// ==== hdl/decode_stage.sv ====
// ############################
// decode, operand read with forwarding, ID/EX register
// unknown opcodes go down the pipe as no-ops
// back end never stalls, so every word is taken
// ############################
`timescale 1ns/10ps
`default_nettype none
`include "mini_mips_config.svh"

module decode_stage import mini_mips_pkg::*; (
    input  wire             aclk,
    input  wire             rst_n,
    input  wire             if_valid,
    input  wire word_t      if_instr,
    input  wire word_t      if_pc,
    // register file read
    output reg_addr_t       ra1,
    output reg_addr_t       ra2,
    input  wire word_t      rd1,
    input  wire word_t      rd2,
    // forwarding from EX
    input  wire word_t      ex_result,
    input  wire             ex_fwd_valid,
    input  wire reg_addr_t  ex_fwd_dst,
    // forwarding from WB
    input  wire             wb_valid,
    input  wire             wb_wen,
    input  wire reg_addr_t  wb_dst,
    input  wire word_t      wb_result,
    // ID/EX register
    output logic            ex_valid,
    output logic            ex_wen,
    output word_t           ex_pc,
    output alu_op_e         ex_op,
    output word_t           ex_a,
    output word_t           ex_b,
    output shamt_t          ex_shamt,
    output reg_addr_t       ex_dst
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    shamt_t      sa;
    logic [15:0] imm;

    alu_op_e     op_dec;
    reg_addr_t   dst_dec;
    word_t       imm_ext;
    logic        use_imm;
    logic        known;
    word_t       src_a;
    word_t       src_b;
    word_t       rt_val;

    assign opcode = if_instr[31:26];
    assign rs     = if_instr[25:21];
    assign rt     = if_instr[20:16];
    assign rd     = if_instr[15:11];
    assign sa     = if_instr[10:6];
    assign funct  = if_instr[5:0];
    assign imm    = if_instr[15:0];

    assign ra1 = rs;
    assign ra2 = rt;

    always_comb begin
        op_dec  = ALU_ADD;
        dst_dec = rd;
        use_imm = 1'b0;
        known   = 1'b1;
        imm_ext = {16'h0000, imm};  // logic immediates zero-extend
        if (opcode == `MM_OP_SPECIAL) begin
            case (funct)
                `MM_FN_ADDU: op_dec = ALU_ADD;
                `MM_FN_SUBU: op_dec = ALU_SUB;
                `MM_FN_AND:  op_dec = ALU_AND;
                `MM_FN_OR:   op_dec = ALU_OR;
                `MM_FN_XOR:  op_dec = ALU_XOR;
                `MM_FN_NOR:  op_dec = ALU_NOR;
                `MM_FN_SLT:  op_dec = ALU_SLT;
                `MM_FN_SLTU: op_dec = ALU_SLTU;
                `MM_FN_SLL:  op_dec = ALU_SLL;
                `MM_FN_SRL:  op_dec = ALU_SRL;
                default:     known  = 1'b0;
            endcase
        end else begin
            dst_dec = rt;
            use_imm = 1'b1;
            case (opcode)
                `MM_OP_ADDIU: begin
                    op_dec  = ALU_ADD;
                    imm_ext = {{16{imm[15]}}, imm};
                end
                `MM_OP_ANDI: op_dec = ALU_AND;
                `MM_OP_ORI:  op_dec = ALU_OR;
                `MM_OP_XORI: op_dec = ALU_XOR;
                `MM_OP_LUI:  op_dec = ALU_LUI;
                default:     known  = 1'b0;
            endcase
        end
    end

    // youngest producer wins: EX, then WB, then the file
    always_comb begin
        src_a = rd1;
        if (wb_valid && wb_wen && (wb_dst == rs)) src_a = wb_result;
        if (ex_fwd_valid && (ex_fwd_dst == rs)) src_a = ex_result;
        rt_val = rd2;
        if (wb_valid && wb_wen && (wb_dst == rt)) rt_val = wb_result;
        if (ex_fwd_valid && (ex_fwd_dst == rt)) rt_val = ex_result;
        src_b = use_imm ? imm_ext : rt_val;
    end

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_wen   <= 1'b0;
        end else begin
            ex_valid <= if_valid;
            ex_wen   <= known && (dst_dec != '0);  // r0 never written
        end
    end

    always_ff @(posedge aclk) begin
        ex_pc    <= if_pc;
        ex_op    <= op_dec;
        ex_a     <= src_a;
        ex_b     <= src_b;
        ex_shamt <= sa;
        ex_dst   <= dst_dec;
    end

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
// ############################
// ALU and EX/WB register
// shifts and LUI work on operand b
// ############################
`timescale 1ns/10ps
`default_nettype none

module execute_stage import mini_mips_pkg::*; (
    input  wire             aclk,
    input  wire             rst_n,
    input  wire             ex_valid,
    input  wire             ex_wen,
    input  wire word_t      ex_pc,
    input  wire alu_op_e    ex_op,
    input  wire word_t      ex_a,
    input  wire word_t      ex_b,
    input  wire shamt_t     ex_shamt,
    input  wire reg_addr_t  ex_dst,
    // forwarding back to decode
    output word_t           ex_result,
    output logic            ex_fwd_valid,
    output reg_addr_t       ex_fwd_dst,
    // write-back
    output logic            wb_valid,
    output logic            wb_wen,
    output word_t           wb_pc,
    output word_t           wb_result,
    output reg_addr_t       wb_dst
);

    always_comb begin
        case (ex_op)
            ALU_ADD:  ex_result = ex_a + ex_b;
            ALU_SUB:  ex_result = ex_a - ex_b;
            ALU_AND:  ex_result = ex_a & ex_b;
            ALU_OR:   ex_result = ex_a | ex_b;
            ALU_XOR:  ex_result = ex_a ^ ex_b;
            ALU_NOR:  ex_result = ~(ex_a | ex_b);
            ALU_SLT:  ex_result = word_t'($signed(ex_a) < $signed(ex_b));
            ALU_SLTU: ex_result = word_t'(ex_a < ex_b);
            ALU_SLL:  ex_result = ex_b << ex_shamt;
            ALU_SRL:  ex_result = ex_b >> ex_shamt;
            ALU_LUI:  ex_result = {ex_b[15:0], 16'h0000};
            default:  ex_result = '0;
        endcase
    end

    assign ex_fwd_valid = ex_valid && ex_wen;  // bubbles never forward
    assign ex_fwd_dst   = ex_dst;

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
            wb_wen   <= 1'b0;
        end else begin
            wb_valid <= ex_valid;
            wb_wen   <= ex_wen;
        end
    end

    always_ff @(posedge aclk) begin
        wb_pc     <= ex_pc;
        wb_result <= ex_result;
        wb_dst    <= ex_dst;
    end

endmodule

`default_nettype wire

// ==== hdl/fetch_unit.sv ====
// ############################
// single-word instruction fetch over an AXI read channel
// one read outstanding, rresp assumed OKAY
// decode must take the word in the cycle if_valid is high
// ############################
`timescale 1ns/10ps
`default_nettype none
`include "mini_mips_config.svh"

module fetch_unit import mini_mips_pkg::*; (
    input  wire         aclk,
    input  wire         rst_n,
    // AXI read channel, master side
    output word_t       araddr,
    output logic        arvalid,
    input  wire         arready,
    input  wire word_t  rdata,
    input  wire         rvalid,
    output logic        rready,
    // to decode
    output logic        if_valid,
    output word_t       if_instr,
    output word_t       if_pc
);

    fetch_state_e state;
    word_t        pc;       // address of the next request

    assign araddr  = pc;
    assign arvalid = (state == FETCH_ADDR);
    assign rready  = (state == FETCH_DATA);

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= FETCH_HOLD;     // so arvalid rises one cycle after reset
            pc       <= `MM_RESET_PC;
            if_valid <= 1'b0;
        end else begin
            if_valid <= 1'b0;
            case (state)
                FETCH_ADDR: begin
                    if (arready) begin
                        state <= FETCH_DATA;
                        pc    <= pc + 32'd4;
                    end
                end
                FETCH_DATA: begin
                    if (rvalid) begin
                        state    <= FETCH_HOLD;
                        if_valid <= 1'b1;   // one-cycle pulse
                    end
                end
                default: state <= FETCH_ADDR;   // held word drains in one cycle
            endcase
        end
    end

    // fetched word and its address
    always_ff @(posedge aclk) begin
        if (arvalid && arready) begin
            if_pc <= pc;
        end
        if (rready && rvalid) begin
            if_instr <= rdata;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mini_mips_config.svh ====
// ############################
// build-time constants for the mini MIPS core
// opcode and funct values follow the MIPS32 encoding, kept subset only
// ############################
`ifndef MINI_MIPS_CONFIG_SVH
`define MINI_MIPS_CONFIG_SVH

`define MM_RESET_PC     32'hBFC0_0000   // first fetch address
`define MM_XLEN         32
`define MM_REG_ADDR_W   5

// primary opcodes
`define MM_OP_SPECIAL   6'h00
`define MM_OP_ADDIU     6'h09
`define MM_OP_ANDI      6'h0c
`define MM_OP_ORI       6'h0d
`define MM_OP_XORI      6'h0e
`define MM_OP_LUI       6'h0f

// funct field, SPECIAL only
`define MM_FN_SLL       6'h00
`define MM_FN_SRL       6'h02
`define MM_FN_ADDU      6'h21
`define MM_FN_SUBU      6'h23
`define MM_FN_AND       6'h24
`define MM_FN_OR        6'h25
`define MM_FN_XOR       6'h26
`define MM_FN_NOR       6'h27
`define MM_FN_SLT       6'h2a
`define MM_FN_SLTU      6'h2b

`endif

// ==== hdl/mini_mips_pkg.sv ====
// ############################
// shared types of the mini MIPS core
// widths come from mini_mips_config.svh
// ############################
`default_nettype none
`include "mini_mips_config.svh"

package mini_mips_pkg;

    typedef logic [`MM_XLEN-1:0]       word_t;      // instr, address, operand
    typedef logic [`MM_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [4:0]                shamt_t;

    // ALU functions, LUI shifts operand b up by 16
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        FETCH_ADDR,     // araddr presented
        FETCH_DATA,     // waiting for the R beat
        FETCH_HOLD      // word handed to decode
    } fetch_state_e;

endpackage

`default_nettype wire

// ==== hdl/mini_mips_top.sv ====
// ############################
// mini MIPS core: fetch, decode, execute, write-back
// AXI read channel only, slave assumed to answer OKAY
// debug port shows each retiring register write
// ############################
`timescale 1ns/10ps
`default_nettype none

module mini_mips_top import mini_mips_pkg::*; (
    input  wire         aclk,
    input  wire         rst_n,
    output word_t       araddr,
    output logic        arvalid,
    input  wire         arready,
    input  wire word_t  rdata,
    input  wire         rvalid,
    output logic        rready,
    output word_t       debug_wb_pc,
    output word_t       debug_wb_rf_wdata,
    output logic [3:0]  debug_wb_rf_wen,
    output reg_addr_t   debug_wb_rf_wnum
);

    logic      if_valid;
    word_t     if_instr;
    word_t     if_pc;
    reg_addr_t ra1;
    reg_addr_t ra2;
    word_t     rd1;
    word_t     rd2;
    logic      ex_valid;
    logic      ex_wen;
    word_t     ex_pc;
    alu_op_e   ex_op;
    word_t     ex_a;
    word_t     ex_b;
    shamt_t    ex_shamt;
    reg_addr_t ex_dst;
    word_t     ex_result;
    logic      ex_fwd_valid;
    reg_addr_t ex_fwd_dst;
    logic      wb_valid;
    logic      wb_wen;
    word_t     wb_pc;
    word_t     wb_result;
    reg_addr_t wb_dst;
    logic      rf_we;

    assign rf_we             = wb_valid && wb_wen;
    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wdata = wb_result;
    assign debug_wb_rf_wen   = {4{rf_we}};  // whole-word write
    assign debug_wb_rf_wnum  = wb_dst;

    fetch_unit fetch_unit_inst (
        .aclk     (aclk),
        .rst_n    (rst_n),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rvalid   (rvalid),
        .rready   (rready),
        .if_valid (if_valid),
        .if_instr (if_instr),
        .if_pc    (if_pc)
    );

    decode_stage decode_stage_inst (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .if_valid     (if_valid),
        .if_instr     (if_instr),
        .if_pc        (if_pc),
        .ra1          (ra1),
        .ra2          (ra2),
        .rd1          (rd1),
        .rd2          (rd2),
        .ex_result    (ex_result),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_dst   (ex_fwd_dst),
        .wb_valid     (wb_valid),
        .wb_wen       (wb_wen),
        .wb_dst       (wb_dst),
        .wb_result    (wb_result),
        .ex_valid     (ex_valid),
        .ex_wen       (ex_wen),
        .ex_pc        (ex_pc),
        .ex_op        (ex_op),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_shamt     (ex_shamt),
        .ex_dst       (ex_dst)
    );

    regfile regfile_inst (
        .aclk  (aclk),
        .rst_n (rst_n),
        .ra1   (ra1),
        .ra2   (ra2),
        .rd1   (rd1),
        .rd2   (rd2),
        .we    (rf_we),
        .wa    (wb_dst),
        .wd    (wb_result)
    );

    execute_stage execute_stage_inst (
        .aclk         (aclk),
        .rst_n        (rst_n),
        .ex_valid     (ex_valid),
        .ex_wen       (ex_wen),
        .ex_pc        (ex_pc),
        .ex_op        (ex_op),
        .ex_a         (ex_a),
        .ex_b         (ex_b),
        .ex_shamt     (ex_shamt),
        .ex_dst       (ex_dst),
        .ex_result    (ex_result),
        .ex_fwd_valid (ex_fwd_valid),
        .ex_fwd_dst   (ex_fwd_dst),
        .wb_valid     (wb_valid),
        .wb_wen       (wb_wen),
        .wb_pc        (wb_pc),
        .wb_result    (wb_result),
        .wb_dst       (wb_dst)
    );

endmodule

`default_nettype wire

// ==== hdl/regfile.sv ====
// ############################
// 32 x 32 register file with 2 read ports and 1 write port
// r0 reads zero and ignores writes
// a read in the cycle of a write returns the old word
// ############################
`timescale 1ns/10ps
`default_nettype none

module regfile import mini_mips_pkg::*; (
    input  wire             aclk,
    input  wire             rst_n,
    input  wire reg_addr_t  ra1,
    input  wire reg_addr_t  ra2,
    output word_t           rd1,
    output word_t           rd2,
    input  wire             we,
    input  wire reg_addr_t  wa,
    input  wire word_t      wd
);

    word_t regs [1:31];

    always_ff @(posedge aclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // decode bypasses the word in write-back
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

// ==== mini_mips.f ====
+incdir+hdl
+incdir+tests
hdl/mini_mips_pkg.sv
hdl/fetch_unit.sv
hdl/regfile.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/mini_mips_top.sv
tests/mini_mips_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the mini MIPS testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module mini_mips_tb -f mini_mips.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/Vmini_mips_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

// ==== tests/isa_model.svh ====
// ############################
// reference model of the kept MIPS subset
// r0 reads zero, unknown opcodes change nothing
// include inside a module that imports mini_mips_pkg
// ############################
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

word_t     model_regs [0:31] = '{default: '0};
word_t     exp_pc [$];      // expected trace, oldest first
word_t     exp_data [$];
reg_addr_t exp_num [$];

// runs one instruction, returns 1 when it writes a register
function automatic bit model_exec(input word_t instr, input word_t pc);
    logic [5:0]  op;
    logic [5:0]  fn;
    logic [15:0] imm;
    reg_addr_t   dst;
    word_t       a;
    word_t       b;
    word_t       res;
    bit          ok;
    op  = instr[31:26];
    fn  = instr[5:0];
    imm = instr[15:0];
    a   = model_regs[instr[25:21]];
    b   = model_regs[instr[20:16]];
    dst = instr[20:16];     // rt for the immediates
    res = '0;
    ok  = 1'b1;
    if (op == `MM_OP_SPECIAL) begin
        dst = instr[15:11];
        case (fn)
            `MM_FN_ADDU: res = a + b;
            `MM_FN_SUBU: res = a - b;
            `MM_FN_AND:  res = a & b;
            `MM_FN_OR:   res = a | b;
            `MM_FN_XOR:  res = a ^ b;
            `MM_FN_NOR:  res = ~(a | b);
            `MM_FN_SLT:  res = {31'b0, ($signed(a) < $signed(b))};
            `MM_FN_SLTU: res = {31'b0, (a < b)};
            `MM_FN_SLL:  res = b << instr[10:6];
            `MM_FN_SRL:  res = b >> instr[10:6];
            default:     ok  = 1'b0;
        endcase
    end else begin
        case (op)
            `MM_OP_ADDIU: res = a + {{16{imm[15]}}, imm};
            `MM_OP_ANDI:  res = a & {16'h0000, imm};
            `MM_OP_ORI:   res = a | {16'h0000, imm};
            `MM_OP_XORI:  res = a ^ {16'h0000, imm};
            `MM_OP_LUI:   res = {imm, 16'h0000};
            default:      ok  = 1'b0;
        endcase
    end
    if (!ok || (dst == '0)) begin
        return 1'b0;
    end
    model_regs[dst] = res;
    exp_pc.push_back(pc);
    exp_data.push_back(res);
    exp_num.push_back(dst);
    return 1'b1;
endfunction

`endif

// ==== tests/mini_mips_tb.sv ====
// ############################
// testbench for mini_mips_top
// random program over r0-r7, read slave stalls 0-3 cycles per channel
// words past the program read as sll r0,r0,0
// ############################
`timescale 1ns/10ps
`default_nettype none
`include "mini_mips_config.svh"

module mini_mips_tb import mini_mips_pkg::*; ();

    localparam int PROG_LEN     = 400;
    localparam int RESET_CYCLES = 16;
    localparam int CLK_PERIOD   = 40;

    logic       aclk    = 1'b0;
    logic       rst_n   = 1'b0;
    logic       arready = 1'b0;
    logic       rvalid  = 1'b0;
    word_t      rdata   = '0;
    word_t      araddr;
    logic       arvalid;
    logic       rready;
    word_t      debug_wb_pc;
    word_t      debug_wb_rf_wdata;
    logic [3:0] debug_wb_rf_wen;
    reg_addr_t  debug_wb_rf_wnum;

    word_t prog [0:PROG_LEN-1];
    bit    nowrite [0:PROG_LEN-1];  // r0 target or unknown opcode
    int    exp_kind [$];            // test number each expected write belongs to
    int    checks [1:6];
    int    errors [1:6];
    int    ar_wait;
    int    r_wait;
    bit    r_pending;
    word_t r_addr;
    word_t next_araddr = `MM_RESET_PC;
    bit    outstanding = 1'b0;
    bit    first_cycle = 1'b1;
    bit    first_ar = 1'b1;
    int    r_beats = 0;
    int    retired = 0;

    `include "isa_model.svh"

    mini_mips_top mini_mips_top_inst (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .araddr            (araddr),
        .arvalid           (arvalid),
        .arready           (arready),
        .rdata             (rdata),
        .rvalid            (rvalid),
        .rready            (rready),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    always #(CLK_PERIOD / 2) aclk = ~aclk;

    function automatic void compare_value(input int test, input string name,
                                          input word_t got, input word_t exp);
        checks[test]++;
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
            errors[test]++;
        end
    endfunction

    function automatic void require_true(input int test, input bit cond, input string what);
        checks[test]++;
        assert (cond) else begin
            $display("test %0d: %s at %0t", test, what, $time);
            errors[test]++;
        end
    endfunction

    function automatic word_t program_word(input word_t addr);
        word_t idx;
        idx = (addr - `MM_RESET_PC) >> 2;
        if (idx < PROG_LEN) begin
            return prog[idx];
        end
        return '0;
    endfunction

    function automatic word_t random_instr();
        int unsigned pick;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        shamt_t      sa;
        logic [15:0] imm;
        logic [5:0]  code;
        pick = $urandom % 40;
        rs   = reg_addr_t'($urandom % 8);     // r0-r7 keeps dependencies dense
        rt   = reg_addr_t'($urandom % 8);
        rd   = reg_addr_t'($urandom % 8);
        sa   = shamt_t'($urandom);
        imm  = 16'($urandom);
        if (pick < 2) begin
            code = 6'h10 | 6'($urandom % 8);  // 0x10-0x17, none kept
            return {code, rs, rt, imm};
        end
        if (pick < 21) begin
            case ($urandom % 10)
                0: code = `MM_FN_ADDU;
                1: code = `MM_FN_SUBU;
                2: code = `MM_FN_AND;
                3: code = `MM_FN_OR;
                4: code = `MM_FN_XOR;
                5: code = `MM_FN_NOR;
                6: code = `MM_FN_SLT;
                7: code = `MM_FN_SLTU;
                8: code = `MM_FN_SLL;
                default: code = `MM_FN_SRL;
            endcase
            if ((code == `MM_FN_SLL) || (code == `MM_FN_SRL)) begin
                return {`MM_OP_SPECIAL, 5'd0, rt, rd, sa, code};
            end
            return {`MM_OP_SPECIAL, rs, rt, rd, 5'd0, code};
        end
        case ($urandom % 5)
            0: code = `MM_OP_ADDIU;
            1: code = `MM_OP_ANDI;
            2: code = `MM_OP_ORI;
            3: code = `MM_OP_XORI;
            default: code = `MM_OP_LUI;
        endcase
        if (code == `MM_OP_LUI) begin
            rs = '0;
        end
        return {code, rs, rt, imm};
    endfunction

    function automatic string test_name(input int t);
        case (t)
            1: return "reset and first fetch";
            2: return "sequential AR addresses";
            3: return "R-type results";
            4: return "immediate extension";
            5: return "forwarding and completeness";
            default: return "r0 and unknown opcodes";
        endcase
    endfunction

    // read slave, one beat per request
    always @(posedge aclk) begin
        if (!rst_n) begin
            arready   <= 1'b0;
            rvalid    <= 1'b0;
            r_pending <= 1'b0;
            ar_wait   <= $urandom % 4;
        end else begin
            if (arvalid && arready) begin
                arready   <= 1'b0;
                r_pending <= 1'b1;
                r_addr    <= araddr;
                r_wait    <= $urandom % 4;
                ar_wait   <= $urandom % 4;     // stall for the next request
            end else if (arvalid) begin
                if (ar_wait == 0) begin
                    arready <= 1'b1;
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (rvalid && rready) begin
                rvalid    <= 1'b0;
                r_pending <= 1'b0;
            end else if (r_pending && !rvalid) begin
                if (r_wait == 0) begin
                    rvalid <= 1'b1;
                    rdata  <= program_word(r_addr);
                end else begin
                    r_wait <= r_wait - 1;
                end
            end
        end
    end

    // handshakes seen here complete on the next rising edge
    always @(negedge aclk) begin
        int    kind;
        word_t slot;
        if (!rst_n) begin
            compare_value(1, "arvalid", word_t'(arvalid), '0);
            compare_value(1, "rready", word_t'(rready), '0);
            compare_value(1, "debug_wb_rf_wen", word_t'(debug_wb_rf_wen), '0);
        end else begin
            if (first_cycle) begin
                compare_value(1, "arvalid", word_t'(arvalid), '0);
                compare_value(1, "debug_wb_rf_wen", word_t'(debug_wb_rf_wen), '0);
                first_cycle = 1'b0;
            end
            require_true(2, !(outstanding && arvalid),
                         "arvalid raised while a read was still outstanding");
            if (arvalid && arready) begin
                compare_value(first_ar ? 1 : 2, "araddr", araddr, next_araddr);
                next_araddr = next_araddr + 32'd4;
                first_ar    = 1'b0;
                outstanding = 1'b1;
            end
            if (rvalid && rready) begin
                outstanding = 1'b0;
                r_beats++;
            end
            if (debug_wb_rf_wen != 4'h0) begin
                retired++;
                slot = (debug_wb_pc - `MM_RESET_PC) >> 2;
                compare_value(6, "debug_wb_rf_wen", word_t'(debug_wb_rf_wen), 32'hf);
                require_true(6, debug_wb_rf_wnum != '0, "a write to r0 reached the trace");
                require_true(6, (slot < PROG_LEN) && !nowrite[slot],
                             "trace entry from an instruction that writes nothing");
                require_true(5, exp_pc.size() != 0, "trace entry with no expected write left");
                if (exp_pc.size() != 0) begin
                    kind = exp_kind.pop_front();
                    compare_value(kind, "debug_wb_pc", debug_wb_pc, exp_pc.pop_front());
                    compare_value(kind, "debug_wb_rf_wdata", debug_wb_rf_wdata,
                                  exp_data.pop_front());
                    compare_value(kind, "debug_wb_rf_wnum", word_t'(debug_wb_rf_wnum),
                                  word_t'(exp_num.pop_front()));
                end
            end
        end
    end

    initial begin
        word_t     instr;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t prev1;
        reg_addr_t prev2;
        bit        dep;
        int        dep_count;
        int        skip_count;
        int        model_writes;
        int        total_err;
        int        total_chk;
        int        passed;
        void'($urandom(39060));
        prev1      = '0;
        prev2      = '0;
        dep_count  = 0;
        skip_count = 0;
        for (int i = 0; i < PROG_LEN; i++) begin
            instr   = random_instr();
            prog[i] = instr;
            rs      = instr[25:21];
            rt      = instr[20:16];
            // reads a result of one of the two writers just before it
            dep = (rs != '0) && ((rs == prev1) || (rs == prev2));
            if (instr[31:26] == `MM_OP_SPECIAL) begin
                dep = dep || ((rt != '0) && ((rt == prev1) || (rt == prev2)));
            end
            nowrite[i] = !model_exec(instr, `MM_RESET_PC + word_t'(4 * i));
            prev2 = prev1;
            prev1 = nowrite[i] ? '0 : exp_num[$];
            if (nowrite[i]) begin
                skip_count++;
            end else if (dep) begin
                dep_count++;
                exp_kind.push_back(5);
            end else begin
                exp_kind.push_back((instr[31:26] == `MM_OP_SPECIAL) ? 3 : 4);
            end
        end
        model_writes = exp_pc.size();

        repeat (RESET_CYCLES) @(posedge aclk);
        rst_n <= 1'b1;
        wait (r_beats >= PROG_LEN + 2);
        repeat (6) @(posedge aclk);    // let the last word drain

        require_true(5, exp_pc.size() == 0,
                     $sformatf("%0d expected writes never reached the trace", exp_pc.size()));
        compare_value(5, "retired writes", word_t'(retired), word_t'(model_writes));
        require_true(5, dep_count > 0, "program holds no dependent instructions");
        require_true(6, skip_count > 0, "program holds no r0 writes or unknown opcodes");

        total_err = 0;
        total_chk = 0;
        passed    = 0;
        for (int t = 1; t <= 6; t++) begin
            $display("test %0d (%s): %0d checks, %0d errors, %s", t, test_name(t),
                     checks[t], errors[t], (errors[t] == 0) ? "ok" : "FAIL");
            total_err += errors[t];
            total_chk += checks[t];
            if (errors[t] == 0) begin
                passed++;
            end
        end
        $display("tests ok %0d of 6, checks %0d, errors %0d", passed, total_chk, total_err);
        if (total_err == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // worst fetch is 11 cycles per word
    initial begin
        #((RESET_CYCLES + PROG_LEN * 12) * CLK_PERIOD);
        $display("timeout: the core did not fetch and retire the program in time");
        $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire
